// ==== hw/mem_params.svh ====
// Build-time sizes and timing for the memory request channel.
// Include wherever a width, depth or refresh constant is needed.
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`define MEM_ADDR_W          8
`define MEM_DATA_W          32

// Register slice depth, requests/responses and waitrequest separately
`define MEM_REG_STAGES      2
`define MEM_WAIT_STAGES     2

`define MEM_QUEUE_DEPTH     32
`define MEM_QUEUE_CNT_W     6
// Margin of two requests per cycle over the whole waitrequest round trip
`define MEM_WAIT_THRESHOLD  (`MEM_QUEUE_DEPTH - 2 * (`MEM_REG_STAGES + `MEM_WAIT_STAGES + 2))

`define MEM_REFRESH_PERIOD  64
`define MEM_REFRESH_CYCLES  6

`endif

// ==== hw/mem_types_pkg.sv ====
// Vector types shared by the slice and the sink.
// Import into a module body, or use scoped names in port lists.
`include "mem_params.svh"

package mem_types_pkg;

    // Word address into the sink RAM
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // One data word, read or write
    typedef logic [`MEM_DATA_W-1:0] mem_data_t;

    // Number of entries held in the sink queue
    typedef logic [`MEM_QUEUE_CNT_W-1:0] mem_occ_t;

endpackage

// ==== hw/mem_ctrl_pkg.sv ====
// Control encodings for the memory sink: FSM states and request kinds.
package mem_ctrl_pkg;

    typedef enum logic
    {
        SERVE,
        REFRESH
    } sink_state_t;

    // Kind tag kept with each queue entry
    typedef logic req_kind_t;
    localparam req_kind_t KIND_READ  = 1'b0;
    localparam req_kind_t KIND_WRITE = 1'b1;

endpackage

// ==== hw/mem_req_reg_slice.sv ====
// Register slice between a read/write request source and a memory sink.
// Waitrequest works as almost-full and travels in its own delay pipeline.
module mem_req_reg_slice
#(
    parameter int N_REG_STAGES  = 1,
    parameter int N_WAIT_STAGES = N_REG_STAGES
)
(
    input  logic                      mem_sink,
    input  logic                      rst_n,

    input  logic                      rd_read,
    input  mem_types_pkg::mem_addr_t  rd_address,
    output logic                      rd_waitrequest,
    output logic                      rd_readdatavalid,
    output mem_types_pkg::mem_data_t  rd_readdata,

    input  logic                      wr_write,
    input  mem_types_pkg::mem_addr_t  wr_address,
    input  mem_types_pkg::mem_data_t  wr_writedata,
    output logic                      wr_waitrequest,

    output logic                      sink_rd_read,
    output mem_types_pkg::mem_addr_t  sink_rd_address,
    output logic                      sink_wr_write,
    output mem_types_pkg::mem_addr_t  sink_wr_address,
    output mem_types_pkg::mem_data_t  sink_wr_writedata,
    input  logic                      sink_waitrequest,
    input  logic                      sink_readdatavalid,
    input  mem_types_pkg::mem_data_t  sink_readdata
);
    import mem_types_pkg::*;

    // Index 0 is the unregistered input side of each path
    logic [N_REG_STAGES:0]  rd_vld;
    mem_addr_t              rd_addr [N_REG_STAGES+1];
    logic [N_REG_STAGES:0]  wr_vld;
    mem_addr_t              wr_addr [N_REG_STAGES+1];
    mem_data_t              wr_data [N_REG_STAGES+1];
    logic [N_REG_STAGES:0]  resp_vld;
    mem_data_t              resp_data [N_REG_STAGES+1];

    logic [N_WAIT_STAGES:0] rd_wait_pipe;
    logic [N_WAIT_STAGES:0] wr_wait_pipe;

    // Requests seen while waitrequest is high are dropped here
    assign rd_vld[0]  = rd_read && !rd_waitrequest;
    assign rd_addr[0] = rd_address;
    assign wr_vld[0]  = wr_write && !wr_waitrequest;
    assign wr_addr[0] = wr_address;
    assign wr_data[0] = wr_writedata;

    assign resp_vld[0]  = sink_readdatavalid;
    assign resp_data[0] = sink_readdata;

    for (genvar s = 1; s <= N_REG_STAGES; s++)
    begin : stage
        always_ff @(posedge mem_sink or negedge rst_n)
        begin
            if (!rst_n)
            begin
                rd_vld[s]   <= 1'b0;
                wr_vld[s]   <= 1'b0;
                resp_vld[s] <= 1'b0;
            end
            else
            begin
                rd_vld[s]   <= rd_vld[s-1];
                wr_vld[s]   <= wr_vld[s-1];
                resp_vld[s] <= resp_vld[s-1];
            end
        end

        always_ff @(posedge mem_sink)
        begin
            rd_addr[s]   <= rd_addr[s-1];
            wr_addr[s]   <= wr_addr[s-1];
            wr_data[s]   <= wr_data[s-1];
            resp_data[s] <= resp_data[s-1];
        end
    end

    assign sink_rd_read      = rd_vld[N_REG_STAGES];
    assign sink_rd_address   = rd_addr[N_REG_STAGES];
    assign sink_wr_write     = wr_vld[N_REG_STAGES];
    assign sink_wr_address   = wr_addr[N_REG_STAGES];
    assign sink_wr_writedata = wr_data[N_REG_STAGES];

    assign rd_readdatavalid = resp_vld[N_REG_STAGES];
    assign rd_readdata      = resp_data[N_REG_STAGES];

    // Sink waitrequest enters at bit 0 of each shift register
    assign rd_wait_pipe[0] = sink_waitrequest;
    assign wr_wait_pipe[0] = sink_waitrequest;

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_wait_pipe[N_WAIT_STAGES:1] <= '0;
            wr_wait_pipe[N_WAIT_STAGES:1] <= '0;
        end
        else
        begin
            rd_wait_pipe[N_WAIT_STAGES:1] <= rd_wait_pipe[N_WAIT_STAGES-1:0];
            wr_wait_pipe[N_WAIT_STAGES:1] <= wr_wait_pipe[N_WAIT_STAGES-1:0];
        end
    end

    assign rd_waitrequest = rd_wait_pipe[N_WAIT_STAGES];
    assign wr_waitrequest = wr_wait_pipe[N_WAIT_STAGES];

endmodule

// ==== hw/mem_refresh_timer.sv ====
// Refresh timing for the memory sink: a due pulse every period and
// a done pulse when a running refresh has lasted its full length.
`include "mem_params.svh"

module mem_refresh_timer
(
    input  logic mem_sink,
    input  logic rst_n,
    input  logic refresh_active,
    output logic refresh_due,
    output logic refresh_done
);
    localparam int PER_W = $clog2(`MEM_REFRESH_PERIOD);
    localparam int LEN_W = $clog2(`MEM_REFRESH_CYCLES);

    logic [PER_W-1:0] period_cnt;
    logic [LEN_W-1:0] len_cnt;

    assign refresh_due  = (period_cnt == PER_W'(`MEM_REFRESH_PERIOD - 1));
    assign refresh_done = refresh_active && (len_cnt == LEN_W'(`MEM_REFRESH_CYCLES - 1));

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            period_cnt <= '0;
            len_cnt    <= '0;
        end
        else
        begin
            // Free running, independent of refresh state
            if (refresh_due)
                period_cnt <= '0;
            else
                period_cnt <= period_cnt + 1'b1;

            // Length counter only advances during a refresh
            if (!refresh_active || refresh_done)
                len_cnt <= '0;
            else
                len_cnt <= len_cnt + 1'b1;
        end
    end

endmodule

// ==== hw/mem_sink_fsm.sv ====
// Sink control: alternates between serving the queue and refresh,
// and raises waitrequest once queue occupancy reaches the threshold.
`include "mem_params.svh"

module mem_sink_fsm
(
    input  logic                     mem_sink,
    input  logic                     rst_n,
    input  logic                     refresh_due,
    input  logic                     refresh_done,
    input  mem_types_pkg::mem_occ_t  occupancy,
    output logic                     refresh_active,
    output logic                     retire_en,
    output logic                     sink_waitrequest
);
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;

    sink_state_t state_q;
    sink_state_t state_d;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            SERVE:
            begin
                if (refresh_due)
                    state_d = REFRESH;
            end
            REFRESH:
            begin
                if (refresh_done)
                    state_d = SERVE;
            end
            default:
                state_d = SERVE;
        endcase
    end

    assign refresh_active = (state_q == REFRESH);

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q          <= SERVE;
            retire_en        <= 1'b0;
            sink_waitrequest <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // Registered copy of the next state, so it tracks state_q
            retire_en <= (state_d == SERVE);
            sink_waitrequest <= (occupancy >= mem_occ_t'(`MEM_WAIT_THRESHOLD));
        end
    end

endmodule

// ==== hw/mem_store.sv ====
// Ordered request queue in front of a word-addressed RAM.
// Takes up to two requests per cycle, write first, and retires one when enabled.
`include "mem_params.svh"

module mem_store
(
    input  logic                      mem_sink,
    input  logic                      rst_n,
    input  logic                      sink_rd_read,
    input  mem_types_pkg::mem_addr_t  sink_rd_address,
    input  logic                      sink_wr_write,
    input  mem_types_pkg::mem_addr_t  sink_wr_address,
    input  mem_types_pkg::mem_data_t  sink_wr_writedata,
    input  logic                      retire_en,
    output mem_types_pkg::mem_occ_t   occupancy,
    output logic                      sink_readdatavalid,
    output mem_types_pkg::mem_data_t  sink_readdata
);
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`MEM_QUEUE_DEPTH);

    req_kind_t        q_kind [`MEM_QUEUE_DEPTH];
    mem_addr_t        q_addr [`MEM_QUEUE_DEPTH];
    mem_data_t        q_data [`MEM_QUEUE_DEPTH];
    mem_data_t        ram [2**`MEM_ADDR_W];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] rd_slot;
    logic             deq;

    // A read arriving with a write goes in behind it
    assign rd_slot = sink_wr_write ? tail + 1'b1 : tail;
    assign deq     = retire_en && (occupancy != '0);

    always_ff @(posedge mem_sink or negedge rst_n)
    begin
        if (!rst_n)
        begin
            head               <= '0;
            tail               <= '0;
            occupancy          <= '0;
            sink_readdatavalid <= 1'b0;
        end
        else
        begin
            tail <= tail + PTR_W'(sink_wr_write) + PTR_W'(sink_rd_read);
            head <= head + PTR_W'(deq);
            occupancy <= occupancy + mem_occ_t'(sink_wr_write) + mem_occ_t'(sink_rd_read)
                         - mem_occ_t'(deq);
            sink_readdatavalid <= deq && (q_kind[head] == KIND_READ);
        end
    end

    always_ff @(posedge mem_sink)
    begin
        if (sink_wr_write)
        begin
            q_kind[tail] <= KIND_WRITE;
            q_addr[tail] <= sink_wr_address;
            q_data[tail] <= sink_wr_writedata;
        end
        if (sink_rd_read)
        begin
            q_kind[rd_slot] <= KIND_READ;
            q_addr[rd_slot] <= sink_rd_address;
        end

        // Head retires in order, so a read sees every earlier write
        if (deq && (q_kind[head] == KIND_WRITE))
            ram[q_addr[head]] <= q_data[head];
        sink_readdata <= ram[q_addr[head]];
    end

endmodule

// ==== hw/mem_subsys_top.sv ====
// Memory subsystem: register slice in front of the queued RAM sink,
// with refresh timing and sink control.
`include "mem_params.svh"

module mem_subsys_top
(
    input  logic                      mem_sink,
    input  logic                      rst_n,
    input  logic                      rd_read,
    input  mem_types_pkg::mem_addr_t  rd_address,
    output logic                      rd_readdatavalid,
    output mem_types_pkg::mem_data_t  rd_readdata,
    input  logic                      wr_write,
    input  mem_types_pkg::mem_addr_t  wr_address,
    input  mem_types_pkg::mem_data_t  wr_writedata,
    output logic                      rd_waitrequest,
    output logic                      wr_waitrequest
);
    import mem_types_pkg::*;

    logic      sink_rd_read;
    mem_addr_t sink_rd_address;
    logic      sink_wr_write;
    mem_addr_t sink_wr_address;
    mem_data_t sink_wr_writedata;
    logic      sink_waitrequest;
    logic      sink_readdatavalid;
    mem_data_t sink_readdata;

    logic      refresh_due;
    logic      refresh_done;
    logic      refresh_active;
    logic      retire_en;
    mem_occ_t  occupancy;

    mem_req_reg_slice
    #(
        .N_REG_STAGES  (`MEM_REG_STAGES),
        .N_WAIT_STAGES (`MEM_WAIT_STAGES)
    )
    slice_i
    (
        .mem_sink, .rst_n,
        .rd_read, .rd_address, .rd_waitrequest, .rd_readdatavalid, .rd_readdata,
        .wr_write, .wr_address, .wr_writedata, .wr_waitrequest,
        .sink_rd_read, .sink_rd_address,
        .sink_wr_write, .sink_wr_address, .sink_wr_writedata,
        .sink_waitrequest, .sink_readdatavalid, .sink_readdata
    );

    mem_refresh_timer timer_i
    (
        .mem_sink, .rst_n, .refresh_active, .refresh_due, .refresh_done
    );

    mem_sink_fsm fsm_i
    (
        .mem_sink, .rst_n, .refresh_due, .refresh_done, .occupancy,
        .refresh_active, .retire_en, .sink_waitrequest
    );

    mem_store store_i
    (
        .mem_sink, .rst_n,
        .sink_rd_read, .sink_rd_address,
        .sink_wr_write, .sink_wr_address, .sink_wr_writedata,
        .retire_en, .occupancy, .sink_readdatavalid, .sink_readdata
    );

endmodule

// ==== dv/mem_subsys_tb.sv ====
// Testbench for the memory subsystem: seeded random reads and writes,
// with read data checked in order against a memory model.
`include "mem_params.svh"

module mem_subsys_tb;
    import mem_types_pkg::*;

    localparam int ADDR_SPACE          = 2**`MEM_ADDR_W;
    localparam int MIX_CYCLES          = 2000;
    localparam int BURST_CYCLES        = 300;
    localparam int REFRESH_TEST_CYCLES = 4 * `MEM_REFRESH_PERIOD;
    localparam int SETTLE_CYCLES       = 20;
    // Init phases allow twice their request count, each drain a full queue plus settle
    localparam int STIM_CYCLES    = 4 * ADDR_SPACE + MIX_CYCLES + BURST_CYCLES
                                    + REFRESH_TEST_CYCLES
                                    + 4 * (`MEM_QUEUE_DEPTH + SETTLE_CYCLES);
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 2 * `MEM_REFRESH_PERIOD + 200;

    logic      mem_sink;
    logic      rst_n;
    logic      rd_read;
    mem_addr_t rd_address;
    logic      rd_readdatavalid;
    mem_data_t rd_readdata;
    logic      wr_write;
    mem_addr_t wr_address;
    mem_data_t wr_writedata;
    logic      rd_waitrequest;
    logic      wr_waitrequest;

    mem_data_t model_mem [ADDR_SPACE];
    mem_data_t expected_q [$];
    string     test_name;
    int        cycle_count;
    logic      saw_waitrequest;

    mem_subsys_top dut_i (.*);

    initial mem_sink = 1'b0;
    always #10 mem_sink = ~mem_sink;

    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    // Sampled at the rising edge, so these are the values of the cycle just ended
    always @(posedge mem_sink)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_failure("timeout: the run did not finish within the cycle limit");
        else if (rst_n)
        begin
            // The sink queues a write ahead of a read from the same cycle
            if (wr_write && !wr_waitrequest)
                model_mem[wr_address] = wr_writedata;
            if (rd_read && !rd_waitrequest)
                expected_q.push_back(model_mem[rd_address]);
            if (rd_waitrequest || wr_waitrequest)
                saw_waitrequest = 1'b1;
            if (rd_readdatavalid)
            begin
                if (expected_q.size() == 0)
                    report_failure("read response arrived with no read outstanding");
                else
                    check_value(test_name, expected_q.pop_front(), rd_readdata);
            end
        end
    end

    // Present one write and hold it until the slice takes it
    task automatic write_word(input mem_addr_t addr, input mem_data_t data);
        wr_write     <= 1'b1;
        wr_address   <= addr;
        wr_writedata <= data;
        @(posedge mem_sink);
        while (wr_waitrequest)
            @(posedge mem_sink);
        wr_write <= 1'b0;
    endtask

    task automatic read_word(input mem_addr_t addr);
        rd_read    <= 1'b1;
        rd_address <= addr;
        @(posedge mem_sink);
        while (rd_waitrequest)
            @(posedge mem_sink);
        rd_read <= 1'b0;
    endtask

    // Hold any pending request until accepted, then go idle
    task automatic release_requests();
        while (rd_read || wr_write)
        begin
            if (!rd_waitrequest)
                rd_read <= 1'b0;
            if (!wr_waitrequest)
                wr_write <= 1'b0;
            @(posedge mem_sink);
        end
    endtask

    task automatic run_traffic(input int cycles, input int rd_pct, input int wr_pct,
                               input int addr_max);
        for (int i = 0; i < cycles; i++)
        begin
            // A request is replaced only once the slice has taken it
            if (!rd_read || !rd_waitrequest)
            begin
                rd_read    <= ($urandom_range(99) < rd_pct);
                rd_address <= mem_addr_t'($urandom_range(addr_max));
            end
            if (!wr_write || !wr_waitrequest)
            begin
                wr_write     <= ($urandom_range(99) < wr_pct);
                wr_address   <= mem_addr_t'($urandom_range(addr_max));
                wr_writedata <= $urandom();
            end
            @(posedge mem_sink);
        end
        release_requests();
    endtask

    task automatic wait_drain();
        @(negedge mem_sink);
        while (expected_q.size() != 0)
            @(negedge mem_sink);
        repeat (SETTLE_CYCLES)
            @(posedge mem_sink);
    endtask

    initial
    begin
        void'($urandom(22196));
        rst_n           = 1'b0;
        rd_read         = 1'b0;
        rd_address      = '0;
        wr_write        = 1'b0;
        wr_address      = '0;
        wr_writedata    = '0;
        cycle_count     = 0;
        saw_waitrequest = 1'b0;
        test_name       = "after_reset";

        repeat (2)
            @(posedge mem_sink);
        rst_n <= 1'b1;
        @(negedge mem_sink);
        check_value("after_reset_readdatavalid", 32'd0, 32'(rd_readdatavalid));
        check_value("after_reset_rd_waitrequest", 32'd0, 32'(rd_waitrequest));
        check_value("after_reset_wr_waitrequest", 32'd0, 32'(wr_waitrequest));
        @(posedge mem_sink);

        test_name = "init_write";
        for (int a = 0; a < ADDR_SPACE; a++)
            write_word(mem_addr_t'(a), $urandom());
        test_name = "init_read";
        for (int a = 0; a < ADDR_SPACE; a++)
            read_word(mem_addr_t'(a));
        wait_drain();

        // Eight addresses keep reads landing right behind writes
        test_name = "random_mix";
        run_traffic(MIX_CYCLES, 60, 60, 7);
        wait_drain();

        test_name = "backpressure";
        saw_waitrequest = 1'b0;
        run_traffic(BURST_CYCLES, 100, 100, ADDR_SPACE - 1);
        wait_drain();
        @(negedge mem_sink);
        check_value("backpressure_waitrequest", 32'd1, 32'(saw_waitrequest));
        @(posedge mem_sink);

        test_name = "refresh";
        run_traffic(REFRESH_TEST_CYCLES, 50, 50, 15);
        wait_drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/mem_types_pkg.sv
hw/mem_ctrl_pkg.sv
hw/mem_req_reg_slice.sv
hw/mem_refresh_timer.sv
hw/mem_sink_fsm.sv
hw/mem_store.sv
hw/mem_subsys_top.sv
dv/mem_subsys_tb.sv
+incdir+hw

// ==== run.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
verilator --binary -f flist.f --top-module mem_subsys_tb -o mem_subsys_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1
cat sim.log
grep -q "^PASS: all tests$" sim.log && exit 0 || exit 1
